//--- logic/FetchTypes.sv
/*
 * Fetch-side sizes shared by the predictor and its top level.
 * Covers the PC type and the fetch and issue widths.
 * Import it into any module that handles PCs or per-slot vectors.
 */

package FetchTypes;

    // Program counter.
    localparam int ADDR_WIDTH = 16;
    typedef logic [ADDR_WIDTH-1:0] AddrPath;

    // Fixed 4-byte instructions, so the low two PC bits are always zero.
    localparam int INSN_BYTE_WIDTH = 4;
    localparam int INSN_ADDR_BIT_WIDTH = 2;

    // Two predictions per fetch group.
    localparam int FETCH_WIDTH = 2;

    // Two branch results per cycle from execute.
    localparam int ISSUE_WIDTH = 2;

endpackage

//--- logic/GshareTypes.sv
/*
 * Predictor structures for the gshare table.
 * Holds the history, index and counter types, the deferred-write entry
 * and the PC/history hash used by both prediction and update.
 */

package GshareTypes;
    import FetchTypes::*;

    localparam int HISTORY_WIDTH = 6;
    localparam int PHT_INDEX_WIDTH = 8;
    localparam int PHT_ENTRY_NUM = 256;
    localparam int PHT_ENTRY_WIDTH = 2;
    localparam int PHT_ENTRY_MAX = 3;
    localparam int PHT_INIT_VALUE = 2;
    localparam int PHT_QUEUE_SIZE = 4;

    typedef logic [HISTORY_WIDTH-1:0] HistoryPath;
    typedef logic [PHT_INDEX_WIDTH-1:0] PhtIndexPath;
    typedef logic [PHT_ENTRY_WIDTH-1:0] PhtEntryPath;
    typedef logic [$clog2(PHT_QUEUE_SIZE)-1:0] PhtQueuePtrPath;

    // One deferred counter write.
    typedef struct packed {
        PhtIndexPath index;
        PhtEntryPath counter;
    } PhtQueueEntry;

    // Word address bits, with the history folded into the upper index bits.
    function automatic PhtIndexPath PhtIndexOf(AddrPath addr, HistoryPath history);
        PhtIndexPath index;
        index = addr[PHT_INDEX_WIDTH+INSN_ADDR_BIT_WIDTH-1:INSN_ADDR_BIT_WIDTH];
        index[PHT_INDEX_WIDTH-1:PHT_INDEX_WIDTH-HISTORY_WIDTH] ^= history;
        return index;
    endfunction

endpackage

//--- logic/GshareIfs.sv
/*
 * Interfaces between the predictor and its storage blocks.
 * BranchResultIf carries executed branches, PhtPortIf the table ports,
 * PhtQueueIf the deferred-write queue.
 */

interface BranchResultIf import FetchTypes::*, GshareTypes::*; ();
    // Plain per-cycle strobes, consumed while valid is high.
    logic [ISSUE_WIDTH-1:0] valid;
    AddrPath brAddr[ISSUE_WIDTH];
    HistoryPath globalHistory[ISSUE_WIDTH];
    PhtEntryPath prevCounter[ISSUE_WIDTH];
    logic [ISSUE_WIDTH-1:0] execTaken;
    logic [ISSUE_WIDTH-1:0] mispred;

    modport source(output valid, brAddr, globalHistory, prevCounter, execTaken, mispred);
    modport predictor(input valid, brAddr, globalHistory, prevCounter, execTaken, mispred);
endinterface

interface PhtPortIf import FetchTypes::*, GshareTypes::*; ();
    logic [ISSUE_WIDTH-1:0] writeEnable;
    PhtIndexPath writeIndex[ISSUE_WIDTH];
    PhtEntryPath writeValue[ISSUE_WIDTH];
    PhtIndexPath readIndex[FETCH_WIDTH];
    // Registered, valid one cycle after readIndex.
    PhtEntryPath readValue[FETCH_WIDTH];

    modport client(output writeEnable, writeIndex, writeValue, readIndex, input readValue);
    modport array(input writeEnable, writeIndex, writeValue, readIndex, output readValue);
endinterface

interface PhtQueueIf import GshareTypes::*; ();
    logic push;
    PhtQueueEntry pushEntry;
    logic pop;
    PhtQueueEntry headEntry;
    logic full;
    logic empty;

    modport client(output push, pushEntry, pop, input headEntry, full, empty);
    modport queue(input push, pushEntry, pop, output headEntry, full, empty);
endinterface

//--- logic/PhtArray.sv
/*
 * Pattern history table storage.
 * Two registered read ports for fetch, two write ports for update.
 * Contents are undefined until the predictor's init sweep completes.
 */

module PhtArray
    import FetchTypes::*;
    import GshareTypes::*;
(
    input logic clock,
    PhtPortIf.array pht
);

    PhtEntryPath counters[PHT_ENTRY_NUM];

    always_ff @(posedge clock) begin
        // Later slots win, so slot 1 takes a collision.
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            if (pht.writeEnable[i]) begin
                counters[pht.writeIndex[i]] <= pht.writeValue[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        // Reads return the value from before this edge's writes.
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pht.readValue[i] <= counters[pht.readIndex[i]];
        end
    end

endmodule

//--- logic/PhtUpdateQueue.sv
/*
 * Circular queue of deferred counter writes.
 * Push stores at the tail on the clock edge; pop advances the head.
 * The head entry is visible combinationally.
 */

module PhtUpdateQueue
    import GshareTypes::*;
(
    input logic clock,
    input logic reset,
    PhtQueueIf.queue q
);

    typedef logic [$bits(PhtQueuePtrPath):0] QueueCount;

    PhtQueueEntry entries[PHT_QUEUE_SIZE];
    PhtQueuePtrPath headPtr;
    PhtQueuePtrPath tailPtr;
    QueueCount count;

    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            // Pointers wrap naturally at the power-of-two depth.
            if (q.push) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (q.pop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({q.push, q.pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (q.push) begin
            entries[tailPtr] <= q.pushEntry;
        end
    end

    assign q.headEntry = entries[headPtr];
    assign q.full = (count == QueueCount'(PHT_QUEUE_SIZE));
    assign q.empty = (count == '0);

endmodule

//--- logic/GsharePredictor.sv
/*
 * Gshare direction prediction and counter update.
 * Hashes the next PC with the speculative history, predicts from the
 * read counters, and schedules result writes directly or via the queue.
 */

module GsharePredictor
    import FetchTypes::*;
    import GshareTypes::*;
(
    input  logic clock,
    input  logic reset,
    input  AddrPath predNextPc,
    input  logic [FETCH_WIDTH-1:0] btbHit,
    input  logic [FETCH_WIDTH-1:0] isCondBr,
    input  logic [FETCH_WIDTH-1:0] updateHistory,
    input  logic recoverHistory,
    input  HistoryPath recoveredHistory,
    BranchResultIf.predictor result,
    PhtPortIf.client pht,
    PhtQueueIf.client q,
    output logic [FETCH_WIDTH-1:0] predTaken,
    output PhtEntryPath phtValue[FETCH_WIDTH],
    output HistoryPath groupHistory,
    output logic ready
);

    HistoryPath history;
    HistoryPath nextHistory;
    logic mispredLast;
    logic shiftStop;
    logic directWrite;
    PhtIndexPath initIndex;
    PhtIndexPath resultIndex[ISSUE_WIDTH];
    PhtEntryPath newValue[ISSUE_WIDTH];

    // Init sweep. The index sits at zero through reset.
    always_ff @(posedge clock) begin
        if (reset) begin
            initIndex <= '0;
            ready <= 1'b0;
        end else if (!ready) begin
            initIndex <= initIndex + 1'b1;
            if (initIndex == PhtIndexPath'(PHT_ENTRY_NUM - 1)) begin
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            history <= '0;
            mispredLast <= 1'b0;
        end else begin
            history <= nextHistory;
            mispredLast <= ready && |(result.valid & result.mispred);
        end
    end

    // Predict the group and build the next history.
    always_comb begin
        shiftStop = 1'b0;
        nextHistory = history;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            phtValue[i] = pht.readValue[i];
            predTaken[i] = btbHit[i] && (pht.readValue[i][PHT_ENTRY_WIDTH-1] || !isCondBr[i]);
            if (!shiftStop && btbHit[i] && isCondBr[i] && updateHistory[i] && !mispredLast) begin
                nextHistory = {nextHistory[HISTORY_WIDTH-2:0], predTaken[i]};
            end
            // Nothing past the first hit belongs to this path.
            shiftStop = shiftStop | btbHit[i];
        end
        if (recoverHistory) begin
            nextHistory = recoveredHistory;
        end
        if (!ready) begin
            nextHistory = '0;
        end
    end

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pht.readIndex[i] = PhtIndexOf(predNextPc + AddrPath'(i * INSN_BYTE_WIDTH),
                                          nextHistory);
        end
    end

    assign groupHistory = history;

    // First valid result writes now; a second one is deferred.
    always_comb begin
        directWrite = 1'b0;
        q.push = 1'b0;
        q.pushEntry = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            resultIndex[i] = PhtIndexOf(result.brAddr[i], result.globalHistory[i]);
            if (result.execTaken[i]) begin
                newValue[i] = (result.prevCounter[i] == PhtEntryPath'(PHT_ENTRY_MAX)) ?
                    result.prevCounter[i] : result.prevCounter[i] + 1'b1;
            end else begin
                newValue[i] = (result.prevCounter[i] == '0) ?
                    result.prevCounter[i] : result.prevCounter[i] - 1'b1;
            end
            pht.writeEnable[i] = 1'b0;
            pht.writeIndex[i] = resultIndex[i];
            pht.writeValue[i] = newValue[i];
            if (ready && result.valid[i]) begin
                if (directWrite) begin
                    q.push = 1'b1;
                    q.pushEntry = '{index: resultIndex[i], counter: newValue[i]};
                end else begin
                    pht.writeEnable[i] = 1'b1;
                    directWrite = 1'b1;
                end
            end
        end
        // Queue drains through slot 0 when no result writes.
        q.pop = ready && !q.empty && !directWrite;
        if (q.pop) begin
            pht.writeEnable[0] = 1'b1;
            pht.writeIndex[0] = q.headEntry.index;
            pht.writeValue[0] = q.headEntry.counter;
        end
        if (!ready) begin
            pht.writeEnable[0] = 1'b1;
            pht.writeIndex[0] = initIndex;
            pht.writeValue[0] = PhtEntryPath'(PHT_INIT_VALUE);
        end
    end

endmodule

//--- logic/GshareTop.sv
/*
 * Gshare predictor top level with plain ports.
 * Builds the three interfaces and connects predictor, table and queue.
 */

module GshareTop
    import FetchTypes::*;
    import GshareTypes::*;
(
    input  logic clock,
    input  logic reset,
    input  AddrPath predNextPc,
    input  logic [FETCH_WIDTH-1:0] btbHit,
    input  logic [FETCH_WIDTH-1:0] isCondBr,
    input  logic [FETCH_WIDTH-1:0] updateHistory,
    input  logic recoverHistory,
    input  HistoryPath recoveredHistory,
    input  logic [ISSUE_WIDTH-1:0] resultValid,
    input  logic [ISSUE_WIDTH-1:0] resultTaken,
    input  logic [ISSUE_WIDTH-1:0] resultMispred,
    input  AddrPath resultAddr[ISSUE_WIDTH],
    input  HistoryPath resultHistory[ISSUE_WIDTH],
    input  PhtEntryPath resultPrevCounter[ISSUE_WIDTH],
    output logic [FETCH_WIDTH-1:0] predTaken,
    output PhtEntryPath phtValue[FETCH_WIDTH],
    output HistoryPath groupHistory,
    output logic ready
);

    BranchResultIf resultIf();
    PhtPortIf phtIf();
    PhtQueueIf queueIf();

    // Execute-stage results.
    assign resultIf.valid = resultValid;
    assign resultIf.brAddr = resultAddr;
    assign resultIf.globalHistory = resultHistory;
    assign resultIf.prevCounter = resultPrevCounter;
    assign resultIf.execTaken = resultTaken;
    assign resultIf.mispred = resultMispred;

    GsharePredictor u_predictor (
        .clock(clock),
        .reset(reset),
        .predNextPc(predNextPc),
        .btbHit(btbHit),
        .isCondBr(isCondBr),
        .updateHistory(updateHistory),
        .recoverHistory(recoverHistory),
        .recoveredHistory(recoveredHistory),
        .result(resultIf),
        .pht(phtIf),
        .q(queueIf),
        .predTaken(predTaken),
        .phtValue(phtValue),
        .groupHistory(groupHistory),
        .ready(ready)
    );

    PhtArray u_phtArray (
        .clock(clock),
        .pht(phtIf)
    );

    PhtUpdateQueue u_phtQueue (
        .clock(clock),
        .reset(reset),
        .q(queueIf)
    );

endmodule

//--- test/Gshare_assert.sv
/*
 * Concurrent checks on the predictor's deferred-write queue traffic.
 * Bound into every GsharePredictor instance.
 */

module GshareAssert (
    input logic clock,
    input logic reset,
    input logic push,
    input logic pop,
    input logic full,
    input logic empty
);

    pushWhenFull: assert property (@(posedge clock) disable iff (reset) !(push && full))
        else $error("update queue pushed while full");

    // A pushed entry is still held at the next edge, even when the head pops.
    pushKept: assert property (@(posedge clock) disable iff (reset) push |=> !empty)
        else $error("update queue empty right after a push");

    // A pop with no push always frees a slot.
    popFrees: assert property (@(posedge clock) disable iff (reset) (pop && !push) |=> !full)
        else $error("update queue still full after a pop");

endmodule

bind GsharePredictor GshareAssert u_gshareAssert (
    .clock(clock),
    .reset(reset),
    .push(q.push),
    .pop(q.pop),
    .full(q.full),
    .empty(q.empty)
);

//--- test/GshareTb.sv
/*
 * Testbench for GshareTop: reset and init sweep, seeded random fetch groups
 * and branch results, all checked each cycle against a reference model.
 */

module GshareTb
    import FetchTypes::*;
    import GshareTypes::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int HIT_CYCLES = 8;
    localparam int RANDOM_CYCLES = 800;
    localparam int SWEEP_CYCLES = 64;
    localparam int TEST_CYCLES = HIT_CYCLES + RANDOM_CYCLES + PHT_QUEUE_SIZE + SWEEP_CYCLES + 4;
    localparam int TIMEOUT_LIMIT = RESET_CYCLES + PHT_ENTRY_NUM + TEST_CYCLES + 100;

    logic clock;
    logic reset;
    AddrPath predNextPc;
    logic [FETCH_WIDTH-1:0] btbHit;
    logic [FETCH_WIDTH-1:0] isCondBr;
    logic [FETCH_WIDTH-1:0] updateHistory;
    logic recoverHistory;
    HistoryPath recoveredHistory;
    logic [ISSUE_WIDTH-1:0] resultValid;
    logic [ISSUE_WIDTH-1:0] resultTaken;
    logic [ISSUE_WIDTH-1:0] resultMispred;
    AddrPath resultAddr[ISSUE_WIDTH];
    HistoryPath resultHistory[ISSUE_WIDTH];
    PhtEntryPath resultPrevCounter[ISSUE_WIDTH];
    logic [FETCH_WIDTH-1:0] predTaken;
    PhtEntryPath phtValue[FETCH_WIDTH];
    HistoryPath groupHistory;
    logic ready;

    // Reference model state.
    PhtEntryPath modelPht[PHT_ENTRY_NUM];
    PhtQueueEntry pending[$];
    PhtEntryPath expRead[FETCH_WIDTH];
    HistoryPath modelHistory = '0;
    logic modelMispred = 1'b0;
    logic modelReady = 1'b0;
    logic readValid = 1'b0;
    logic lastDual = 1'b0;
    int sinceRelease = 0;
    int seed = 30591;
    int errors = 0;
    int checks = 0;
    int cycleCount = 0;

    GshareTop u_dut (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > TIMEOUT_LIMIT) begin
            $display("Timeout: the run went past %0d cycles", TIMEOUT_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // 2-bit saturating counter training.
    function automatic PhtEntryPath trainCounter(PhtEntryPath prev, logic taken);
        if (taken) begin
            return (prev == PhtEntryPath'(PHT_ENTRY_MAX)) ? prev : prev + 2'd1;
        end
        return (prev == 2'd0) ? prev : prev - 2'd1;
    endfunction

    task automatic driveIdle(AddrPath pc);
        predNextPc = pc;
        btbHit = '0;
        isCondBr = '0;
        updateHistory = '0;
        recoverHistory = 1'b0;
        recoveredHistory = '0;
        resultValid = '0;
        resultTaken = '0;
        resultMispred = '0;
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            resultAddr[i] = '0;
            resultHistory[i] = '0;
            resultPrevCounter[i] = '0;
        end
    endtask

    task automatic driveRandom();
        logic [31:0] rnd;
        logic [ISSUE_WIDTH-1:0] valid;
        rnd = $random(seed);
        predNextPc = {10'h0, rnd[2:0], 3'b000};
        btbHit = rnd[6:5];
        isCondBr = rnd[8:7];
        updateHistory = rnd[10:9];
        recoverHistory = (rnd[14:11] == 4'h0);
        recoveredHistory = rnd[20:15];
        valid = rnd[22:21];
        // Keep dual-result cycles apart and the queue below overflow.
        if (valid == 2'b11 && (lastDual || pending.size() >= PHT_QUEUE_SIZE)) begin
            valid = 2'b01;
        end
        lastDual = (valid == 2'b11);
        resultValid = valid;
        resultTaken = rnd[24:23];
        resultMispred = rnd[26:25] & rnd[28:27];
        for (int i = 0; i < ISSUE_WIDTH; i++) begin
            rnd = $random(seed);
            resultAddr[i] = {11'h0, rnd[2:0], 2'b00};
            resultHistory[i] = {4'h0, rnd[4:3]};
            resultPrevCounter[i] = modelPht[PhtIndexOf(resultAddr[i], resultHistory[i])];
        end
    endtask

    // Samples the outputs mid-cycle, checks them, then advances the model by one edge.
    task automatic checkAndModel();
        logic expReady;
        logic stop;
        logic direct;
        logic [FETCH_WIDTH-1:0] expTaken;
        HistoryPath nextHist;
        PhtQueueEntry entry;
        @(negedge clock);
        expReady = !reset && sinceRelease >= PHT_ENTRY_NUM;
        if (expReady && !modelReady) begin
            for (int j = 0; j < PHT_ENTRY_NUM; j++) begin
                modelPht[j] = PhtEntryPath'(PHT_INIT_VALUE);
            end
            modelReady = 1'b1;
        end
        checks++;
        if (ready !== expReady) begin
            errors++;
            $display("** Error: ready = %h, expected %h", ready, expReady);
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            expTaken[i] = btbHit[i] && (!isCondBr[i] || expRead[i][PHT_ENTRY_WIDTH-1]);
            if (expReady && readValid) begin
                checks += 2;
                if (phtValue[i] !== expRead[i]) begin
                    errors++;
                    $display("** Error: phtValue[%0d] = %h, expected %h",
                             i, phtValue[i], expRead[i]);
                end
                if (predTaken[i] !== expTaken[i]) begin
                    errors++;
                    $display("** Error: predTaken[%0d] = %h, expected %h",
                             i, predTaken[i], expTaken[i]);
                end
            end
        end
        if (expReady) begin
            checks++;
            if (groupHistory !== modelHistory) begin
                errors++;
                $display("** Error: groupHistory = %h, expected %h", groupHistory, modelHistory);
            end
        end
        // Shift conditional hits up to and including the first hit.
        nextHist = modelHistory;
        stop = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!stop && btbHit[i] && isCondBr[i] && updateHistory[i] && !modelMispred) begin
                nextHist = {nextHist[HISTORY_WIDTH-2:0], expTaken[i]};
            end
            stop = stop | btbHit[i];
        end
        if (recoverHistory) begin
            nextHist = recoveredHistory;
        end
        if (!expReady) begin
            nextHist = '0;
        end
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            expRead[i] = modelPht[PhtIndexOf(predNextPc + AddrPath'(i * INSN_BYTE_WIDTH),
                                             nextHist)];
        end
        readValid = expReady;
        direct = 1'b0;
        if (expReady) begin
            for (int i = 0; i < ISSUE_WIDTH; i++) begin
                if (resultValid[i]) begin
                    entry.index = PhtIndexOf(resultAddr[i], resultHistory[i]);
                    entry.counter = trainCounter(resultPrevCounter[i], resultTaken[i]);
                    if (direct) begin
                        pending.push_back(entry);
                    end else begin
                        modelPht[entry.index] = entry.counter;
                        direct = 1'b1;
                    end
                end
            end
            if (!direct && pending.size() > 0) begin
                entry = pending.pop_front();
                modelPht[entry.index] = entry.counter;
            end
        end
        modelMispred = expReady && |(resultValid & resultMispred);
        modelHistory = nextHist;
        if (!reset) begin
            sinceRelease++;
        end
    endtask

    task automatic idleCycle(AddrPath pc);
        @(posedge clock);
        #2;
        driveIdle(pc);
        checkAndModel();
    endtask

    initial begin
        reset = 1'b1;
        driveIdle('0);
        repeat (RESET_CYCLES - 1) idleCycle('0);
        @(posedge clock);
        #2;
        reset = 1'b0;
        driveIdle('0);
        checkAndModel();
        // The model expects ready after exactly one table sweep.
        repeat (PHT_ENTRY_NUM + 1) idleCycle('0);
        repeat (HIT_CYCLES) begin
            @(posedge clock);
            #2;
            driveIdle(AddrPath'({$random(seed)} % 16'hfffc));
            btbHit = '1;
            isCondBr = '1;
            updateHistory = '1;
            checkAndModel();
        end
        repeat (RANDOM_CYCLES) begin
            @(posedge clock);
            #2;
            driveRandom();
            checkAndModel();
        end
        while (pending.size() > 0) begin
            idleCycle('0);
        end
        // Read back the trained region with a cleared history.
        @(posedge clock);
        #2;
        driveIdle('0);
        recoverHistory = 1'b1;
        checkAndModel();
        for (int i = 0; i < SWEEP_CYCLES; i++) begin
            idleCycle(AddrPath'(i * 2 * INSN_BYTE_WIDTH));
        end
        idleCycle('0);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- gshare.f
logic/FetchTypes.sv
logic/GshareTypes.sv
logic/GshareIfs.sv
logic/PhtArray.sv
logic/PhtUpdateQueue.sv
logic/GsharePredictor.sv
logic/GshareTop.sv
test/Gshare_assert.sv
test/GshareTb.sv

//--- Makefile
# Verilator build and run for the gshare predictor testbench.

VERILATOR ?= verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = GshareTb
FILELIST  = gshare.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run passes only if the log holds the pass line.
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
